/* rtl/rope_params.svh */
// rope game constants
`ifndef ROPE_PARAMS_SVH
`define ROPE_PARAMS_SVH

// pivot of the rope
`define ROPE_ORIGIN_X 77
`define ROPE_ORIGIN_Y 45

`define ROPE_MIN 20
`define ROPE_DELTA 5

`define ANGLE_MIN 15
`define ANGLE_MAX 165
`define ANGLE_REST 90

`define SCREEN_W 320
`define SCREEN_H 240

// extend stops past these
`define EDGE_LEFT 2
`define EDGE_RIGHT 318
`define EDGE_BOTTOM 238

`define SPRITE_SIZE 16
`define HIT_MARGIN_Y 6
`define CARRY_OFFSET 4
`define COLLECT_LEN 30

// frames per reel step
`define UP_FRAMES_EMPTY 2
`define UP_FRAMES_LOADED 5

`define SCORE_STONE 10
`define SCORE_GOLD 20
`define SCORE_DIAMOND 50

`define ITEM_SLOTS 16

`endif

/* rtl/rope_pkg.sv */
// rope game shared types
`default_nettype none

package rope_pkg;

    // one entry of the item table
    typedef struct packed {
        logic [8:0] x;
        logic [3:0] pad_x;
        logic [7:0] y;
        logic [6:0] pad_y;
        // 0 stone, 1 gold, 2 or 3 diamond
        logic [1:0] kind;
        logic       visible;
        logic       moving;
    } item_t;

    // rope end in screen pixels
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } point_t;

    typedef enum logic [1:0] {
        KIND_STONE   = 2'd0,
        KIND_GOLD    = 2'd1,
        KIND_DIAMOND = 2'd2
    } item_kind_t;

endpackage

`default_nettype wire

/* rtl/rope_geometry.sv */
// rope end point from angle and length
`timescale 1ns/10ps
`default_nettype none
`include "rope_params.svh"

module rope_geometry (
    input  wire                    clock,
    input  wire                    resetn,
    input  wire [7:0]              degree,
    input  wire [9:0]              rope_len,
    output rope_pkg::point_t       end_point
);

    // quarter wave, sin(0..90 deg) times 256
    logic [8:0]  sine_table [0:90];
    logic [6:0]  sin_idx;
    logic [6:0]  cos_idx;
    logic        cos_neg;
    logic [18:0] x_prod;
    logic [18:0] y_prod;

    initial begin
        $readmemh("rtl/sine_quarter.hex", sine_table);
    end

    // fold the angle into the first quadrant
    always_comb begin
        if (degree > 8'd90) begin
            sin_idx = 7'(8'd180 - degree);
            cos_idx = 7'(degree - 8'd90);
            cos_neg = 1'b1;
        end else begin
            sin_idx = 7'(degree);
            cos_idx = 7'(8'd90 - degree);
            cos_neg = 1'b0;
        end
    end

    assign x_prod = rope_len * sine_table[cos_idx];
    assign y_prod = rope_len * sine_table[sin_idx];

    // reset value is the rest geometry
    always_ff @(posedge clock) begin
        if (!resetn) begin
            end_point.x <= 10'(`ROPE_ORIGIN_X);
            end_point.y <= 10'(`ROPE_ORIGIN_Y + `ROPE_MIN);
        end else begin
            if (cos_neg) begin
                end_point.x <= 10'(`ROPE_ORIGIN_X) - x_prod[17:8];
            end else begin
                end_point.x <= 10'(`ROPE_ORIGIN_X) + x_prod[17:8];
            end
            end_point.y <= 10'(`ROPE_ORIGIN_Y) + y_prod[17:8];
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_timer.sv */
// frame count timer
`timescale 1ns/10ps
`default_nettype none

module frame_timer #(
    parameter int frame_cycles = 833334
) (
    input  wire       clock,
    input  wire       resetn,
    input  wire       start,
    input  wire [2:0] frames,
    output logic      done
);

    localparam int count_width = $clog2(frame_cycles + 1);

    logic [count_width-1:0] cycle_cnt;
    logic [2:0]             frames_left;
    logic                   busy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            cycle_cnt   <= '0;
            frames_left <= '0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // a new request drops any running count
                cycle_cnt   <= '0;
                frames_left <= frames;
                busy        <= 1'b1;
            end else if (busy) begin
                if (cycle_cnt == count_width'(frame_cycles - 1)) begin
                    cycle_cnt   <= '0;
                    frames_left <= frames_left - 3'd1;
                    // zero frames behaves like one
                    if (frames_left <= 3'd1) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/item_ram.sv */
// dual port item table
`timescale 1ns/10ps
`default_nettype none
`include "rope_params.svh"

module item_ram (
    input  wire                   clock,
    input  wire [3:0]             a_addr,
    input  wire                   a_we,
    input  wire rope_pkg::item_t  a_wdata,
    output rope_pkg::item_t       a_rdata,
    input  wire [3:0]             b_addr,
    input  wire                   b_we,
    input  wire rope_pkg::item_t  b_wdata,
    output rope_pkg::item_t       b_rdata
);

    rope_pkg::item_t mem [0:`ITEM_SLOTS-1];

    // read before write on each port
    always @(posedge clock) begin
        a_rdata <= mem[a_addr];
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
    end

    always @(posedge clock) begin
        b_rdata <= mem[b_addr];
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/rope_controller.sv */
// rope swing, grab and reel control
`timescale 1ns/10ps
`default_nettype none
`include "rope_params.svh"

module rope_controller (
    input  wire                    clock,
    input  wire                    resetn,
    input  wire                    enable,
    input  wire                    fire,
    input  wire [3:0]              quantity,
    input  wire rope_pkg::point_t  end_point,
    input  wire                    frame_done,
    input  wire rope_pkg::item_t   rdata,
    output logic [7:0]             degree,
    output logic [9:0]             rope_len,
    output logic [9:0]             score,
    output logic                   frame_start,
    output logic [2:0]             frame_count,
    output logic [3:0]             ram_addr,
    output logic                   ram_we,
    output rope_pkg::item_t        ram_wdata
);

    typedef enum logic [3:0] {
        ST_STOP,
        ST_SWING,
        ST_EXTEND,
        ST_EXT_SETTLE,
        ST_EDGE,
        ST_SCAN_WAIT,
        ST_SCAN_CHECK,
        ST_REEL,
        ST_REEL_SETTLE,
        ST_REEL_POS
    } state_t;

    state_t          state;
    logic            swing_cw;
    logic            fire_pending;
    logic            loaded;
    logic            collect;
    logic            hit;
    logic            off_edge;
    logic [1:0]      carry_kind;
    logic [9:0]      item_x;
    logic [9:0]      item_y;
    logic [9:0]      x_hi;
    logic [9:0]      y_lo;
    logic [9:0]      y_hi;
    rope_pkg::item_t grab_word;
    rope_pkg::item_t carry_word;
    rope_pkg::item_t drop_word;

    function automatic logic [9:0] kind_points(input logic [1:0] kind);
        case (rope_pkg::item_kind_t'(kind))
            rope_pkg::KIND_STONE: kind_points = 10'(`SCORE_STONE);
            rope_pkg::KIND_GOLD:  kind_points = 10'(`SCORE_GOLD);
            // kind 3 also counts as diamond
            default:              kind_points = 10'(`SCORE_DIAMOND);
        endcase
    endfunction

    assign off_edge = (end_point.x < 10'(`EDGE_LEFT)) || (end_point.x >= 10'(`EDGE_RIGHT))
                   || (end_point.y >= 10'(`EDGE_BOTTOM));

    // hitbox of the slot being scanned
    assign item_x = {1'b0, rdata.x};
    assign item_y = {2'b0, rdata.y};
    assign x_hi = (item_x + 10'(`SPRITE_SIZE) < 10'(`SCREEN_W)) ?
                  item_x + 10'(`SPRITE_SIZE) : 10'(`SCREEN_W);
    assign y_hi = (item_y + 10'(`SPRITE_SIZE) < 10'(`SCREEN_H)) ?
                  item_y + 10'(`SPRITE_SIZE) : 10'(`SCREEN_H);
    assign y_lo = (item_y > 10'(`HIT_MARGIN_Y)) ? item_y - 10'(`HIT_MARGIN_Y) : 10'd0;
    assign hit = rdata.visible && !rdata.moving && (item_x < end_point.x)
              && (end_point.x <= x_hi) && (y_lo < end_point.y) && (end_point.y <= y_hi);

    assign collect = loaded && (rope_len < 10'(`COLLECT_LEN));

    always_comb begin
        grab_word = rdata;
        grab_word.moving = 1'b1;
        // carried item hangs just off the rope end
        carry_word = '0;
        carry_word.x = end_point.x[8:0] - 9'(`CARRY_OFFSET);
        carry_word.y = end_point.y[7:0] - 8'(`CARRY_OFFSET);
        carry_word.kind = carry_kind;
        carry_word.visible = 1'b1;
        carry_word.moving = 1'b1;
        drop_word = carry_word;
        drop_word.visible = 1'b0;
        drop_word.moving = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state        <= ST_STOP;
            degree       <= 8'(`ANGLE_REST);
            rope_len     <= 10'(`ROPE_MIN);
            score        <= '0;
            swing_cw     <= 1'b0;
            fire_pending <= 1'b0;
            loaded       <= 1'b0;
            frame_start  <= 1'b0;
            frame_count  <= '0;
            ram_addr     <= '0;
            ram_we       <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            ram_we      <= 1'b0;
            case (state)
                ST_STOP: begin
                    degree       <= 8'(`ANGLE_REST);
                    rope_len     <= 10'(`ROPE_MIN);
                    swing_cw     <= 1'b0;
                    fire_pending <= 1'b0;
                    if (enable) begin
                        frame_start <= 1'b1;
                        frame_count <= 3'd1;
                        state       <= ST_SWING;
                    end
                end
                ST_SWING: begin
                    if (fire) begin
                        fire_pending <= 1'b1;
                    end
                    if (frame_done) begin
                        frame_start <= 1'b1;
                        frame_count <= 3'd1;
                        if (fire_pending || fire) begin
                            // angle freezes for the shot
                            fire_pending <= 1'b0;
                            state        <= ST_EXTEND;
                        end else if (swing_cw) begin
                            degree <= degree + 8'd1;
                            if (degree + 8'd1 == 8'(`ANGLE_MAX)) begin
                                swing_cw <= 1'b0;
                            end
                        end else begin
                            degree <= degree - 8'd1;
                            if (degree - 8'd1 == 8'(`ANGLE_MIN)) begin
                                swing_cw <= 1'b1;
                            end
                        end
                    end
                end
                ST_EXTEND: begin
                    if (frame_done) begin
                        rope_len <= rope_len + 10'(`ROPE_DELTA);
                        state    <= ST_EXT_SETTLE;
                    end
                end
                // geometry needs a cycle for the new length
                ST_EXT_SETTLE: state <= ST_EDGE;
                ST_EDGE: begin
                    if (off_edge) begin
                        frame_start <= 1'b1;
                        frame_count <= 3'(`UP_FRAMES_EMPTY);
                        state       <= ST_REEL;
                    end else if (quantity == 4'd0) begin
                        frame_start <= 1'b1;
                        frame_count <= 3'd1;
                        state       <= ST_EXTEND;
                    end else begin
                        ram_addr <= '0;
                        state    <= ST_SCAN_WAIT;
                    end
                end
                ST_SCAN_WAIT: state <= ST_SCAN_CHECK;
                ST_SCAN_CHECK: begin
                    if (hit) begin
                        ram_we      <= 1'b1;
                        ram_wdata   <= grab_word;
                        carry_kind  <= rdata.kind;
                        loaded      <= 1'b1;
                        frame_start <= 1'b1;
                        frame_count <= 3'(`UP_FRAMES_LOADED);
                        state       <= ST_REEL;
                    end else if (ram_addr + 4'd1 == quantity) begin
                        frame_start <= 1'b1;
                        frame_count <= 3'd1;
                        state       <= ST_EXTEND;
                    end else begin
                        ram_addr <= ram_addr + 4'd1;
                        state    <= ST_SCAN_WAIT;
                    end
                end
                ST_REEL: begin
                    if (frame_done) begin
                        rope_len <= rope_len - 10'(`ROPE_DELTA);
                        state    <= ST_REEL_SETTLE;
                    end
                end
                ST_REEL_SETTLE: state <= ST_REEL_POS;
                ST_REEL_POS: begin
                    // ram_addr still points at the caught slot
                    if (collect) begin
                        ram_we    <= 1'b1;
                        ram_wdata <= drop_word;
                        score     <= score + kind_points(carry_kind);
                        loaded    <= 1'b0;
                    end else if (loaded) begin
                        ram_we    <= 1'b1;
                        ram_wdata <= carry_word;
                    end
                    frame_start <= 1'b1;
                    if (rope_len <= 10'(`ROPE_MIN)) begin
                        frame_count <= 3'd1;
                        state       <= ST_SWING;
                    end else if (loaded && !collect) begin
                        frame_count <= 3'(`UP_FRAMES_LOADED);
                        state       <= ST_REEL;
                    end else begin
                        frame_count <= 3'(`UP_FRAMES_EMPTY);
                        state       <= ST_REEL;
                    end
                end
                default: state <= ST_STOP;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/rope_top.sv */
// rope game top level
`timescale 1ns/10ps
`default_nettype none

module rope_top #(
    parameter int frame_cycles = 833334
) (
    input  wire                   clock,
    input  wire                   resetn,
    input  wire                   enable,
    input  wire                   fire,
    input  wire [3:0]             quantity,
    input  wire [3:0]             item_addr,
    input  wire                   item_we,
    input  wire rope_pkg::item_t  item_wdata,
    output rope_pkg::item_t       item_rdata,
    output rope_pkg::point_t      end_point,
    output logic [7:0]            degree,
    output logic [9:0]            rope_len,
    output logic [9:0]            score
);

    logic            frame_start;
    logic [2:0]      frame_count;
    logic            frame_done;
    logic [3:0]      ram_addr;
    logic            ram_we;
    rope_pkg::item_t ram_wdata;
    rope_pkg::item_t ram_rdata;

    rope_controller u_controller (
        .clock       (clock),
        .resetn      (resetn),
        .enable      (enable),
        .fire        (fire),
        .quantity    (quantity),
        .end_point   (end_point),
        .frame_done  (frame_done),
        .rdata       (ram_rdata),
        .degree      (degree),
        .rope_len    (rope_len),
        .score       (score),
        .frame_start (frame_start),
        .frame_count (frame_count),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .ram_wdata   (ram_wdata)
    );

    rope_geometry u_geometry (
        .clock     (clock),
        .resetn    (resetn),
        .degree    (degree),
        .rope_len  (rope_len),
        .end_point (end_point)
    );

    frame_timer #(
        .frame_cycles (frame_cycles)
    ) u_frame_timer (
        .clock  (clock),
        .resetn (resetn),
        .start  (frame_start),
        .frames (frame_count),
        .done   (frame_done)
    );

    // port b is the level loader side
    item_ram u_item_ram (
        .clock   (clock),
        .a_addr  (ram_addr),
        .a_we    (ram_we),
        .a_wdata (ram_wdata),
        .a_rdata (ram_rdata),
        .b_addr  (item_addr),
        .b_we    (item_we),
        .b_wdata (item_wdata),
        .b_rdata (item_rdata)
    );

endmodule

`default_nettype wire

/* dv/rope_tb.sv */
// rope controller testbench
`timescale 1ns/10ps
`default_nettype none
`include "rope_params.svh"

module rope_tb;

    // cycle budgets per test
    localparam int budget_reset = 50;
    localparam int budget_port  = 100;
    localparam int budget_swing = 1500;
    localparam int budget_miss  = 800;
    localparam int budget_grab  = 800;
    localparam int cycle_limit  = budget_reset + budget_port + budget_swing
                                + budget_miss + budget_grab + 200;

    logic             clock = 1'b0;
    logic             resetn;
    logic             enable;
    logic             fire;
    logic [3:0]       quantity;
    logic [3:0]       item_addr;
    logic             item_we;
    rope_pkg::item_t  item_wdata;
    rope_pkg::item_t  item_rdata;
    rope_pkg::point_t end_point;
    logic [7:0]       degree;
    logic [9:0]       rope_len;
    logic [9:0]       score;

    logic [8:0] sine_ref [0:90];
    logic       check_on = 1'b0;
    integer     seed = 32'h0233_3c27;
    int         cycle_count = 0;
    int         fail_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         fail_at_start;
    string      test_name = "setup";

    rope_top #(.frame_cycles(4)) DUT (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .fire       (fire),
        .quantity   (quantity),
        .item_addr  (item_addr),
        .item_we    (item_we),
        .item_wdata (item_wdata),
        .item_rdata (item_rdata),
        .end_point  (end_point),
        .degree     (degree),
        .rope_len   (rope_len),
        .score      (score)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout in test %s after %0d cycles", test_name, cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // end point from angle and length by the sine table
    function automatic rope_pkg::point_t model_point(input logic [7:0] deg,
                                                     input logic [9:0] len);
        int s_idx;
        int c_idx;
        int dx;
        int dy;
        rope_pkg::point_t p;
        if (deg > 8'd90) begin
            s_idx = 180 - int'(deg);
            c_idx = int'(deg) - 90;
        end else begin
            s_idx = int'(deg);
            c_idx = 90 - int'(deg);
        end
        dx = (int'(len) * int'(sine_ref[c_idx])) / 256;
        dy = (int'(len) * int'(sine_ref[s_idx])) / 256;
        if (deg > 8'd90) begin
            p.x = 10'(`ROPE_ORIGIN_X - dx);
        end else begin
            p.x = 10'(`ROPE_ORIGIN_X + dx);
        end
        p.y = 10'(`ROPE_ORIGIN_Y + dy);
        return p;
    endfunction

    function automatic logic outside_edges(input rope_pkg::point_t p);
        return (p.x < `EDGE_LEFT) || (p.x >= `EDGE_RIGHT) || (p.y >= `EDGE_BOTTOM);
    endfunction

    function automatic logic in_hitbox(input rope_pkg::item_t it, input rope_pkg::point_t p);
        int ix;
        int iy;
        int x_hi;
        int y_lo;
        int y_hi;
        ix = int'(it.x);
        iy = int'(it.y);
        x_hi = (ix + `SPRITE_SIZE < `SCREEN_W) ? ix + `SPRITE_SIZE : `SCREEN_W;
        y_lo = (iy - `HIT_MARGIN_Y > 0) ? iy - `HIT_MARGIN_Y : 0;
        y_hi = (iy + `SPRITE_SIZE < `SCREEN_H) ? iy + `SPRITE_SIZE : `SCREEN_H;
        return it.visible && !it.moving && (ix < int'(p.x)) && (int'(p.x) <= x_hi)
            && (y_lo < int'(p.y)) && (int'(p.y) <= y_hi);
    endfunction

    function automatic int kind_score(input logic [1:0] kind);
        if (kind == 2'd0) begin
            return `SCORE_STONE;
        end else if (kind == 2'd1) begin
            return `SCORE_GOLD;
        end
        return `SCORE_DIAMOND;
    endfunction

    a_geometry: assert property (@(posedge clock) disable iff (!check_on)
        end_point == model_point($past(degree), $past(rope_len)))
    else begin
        fail_count = fail_count + 1;
        $display("FAILED %s end_point expected %h actual %h", test_name,
                 model_point($past(degree), $past(rope_len)), $sampled(end_point));
    end

    a_degree_step: assert property (@(posedge clock) disable iff (!check_on)
        (degree != $past(degree)) |-> (degree == $past(degree) + 8'd1
                                       || degree == $past(degree) - 8'd1))
    else begin
        fail_count = fail_count + 1;
        $display("FAILED %s degree step expected %0d +/- 1 actual %0d", test_name,
                 $past(degree), $sampled(degree));
    end

    a_degree_range: assert property (@(posedge clock) disable iff (!check_on)
        (degree >= `ANGLE_MIN) && (degree <= `ANGLE_MAX))
    else begin
        fail_count = fail_count + 1;
        $display("degree %0d left the swing range in test %s", $sampled(degree), test_name);
    end

    a_len_step: assert property (@(posedge clock) disable iff (!check_on)
        (rope_len != $past(rope_len)) |-> (rope_len == $past(rope_len) + `ROPE_DELTA
                                           || rope_len == $past(rope_len) - `ROPE_DELTA))
    else begin
        fail_count = fail_count + 1;
        $display("FAILED %s rope_len step expected %0d +/- 5 actual %0d", test_name,
                 $past(rope_len), $sampled(rope_len));
    end

    // the angle is frozen while the rope is out
    a_angle_frozen: assert property (@(posedge clock) disable iff (!check_on)
        (rope_len != `ROPE_MIN) |-> $stable(degree))
    else begin
        fail_count = fail_count + 1;
        $display("degree moved while the rope was out in test %s", test_name);
    end

    task automatic wait_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (expected == actual)
        else begin
            fail_count = fail_count + 1;
            $display("FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic apply_reset();
        check_on = 1'b0;
        resetn = 1'b0;
        repeat (2) wait_cycle();
        resetn = 1'b1;
        repeat (2) wait_cycle();
        check_on = 1'b1;
    endtask

    task automatic write_item(input logic [3:0] addr, input rope_pkg::item_t word);
        item_addr  = addr;
        item_wdata = word;
        item_we    = 1'b1;
        wait_cycle();
        item_we = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        fail_at_start = fail_count;
    endtask

    task automatic end_test();
        if (fail_count == fail_at_start) begin
            tests_passed = tests_passed + 1;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAIL", test_name);
        end
    endtask

    task automatic wait_degree(input int target);
        while (degree != target) begin
            wait_cycle();
        end
    endtask

    // follow one shot until the rope first shrinks
    task automatic follow_shot(output int frozen, output int peak);
        int prev;
        while (rope_len == `ROPE_MIN) begin
            wait_cycle();
        end
        frozen = degree;
        prev = rope_len;
        forever begin
            wait_cycle();
            if (rope_len > prev) begin
                prev = rope_len;
            end else if (rope_len < prev) begin
                break;
            end
        end
        peak = prev;
    endtask

    initial begin
        rope_pkg::item_t  words [4];
        rope_pkg::item_t  target;
        rope_pkg::item_t  last_word;
        rope_pkg::point_t p;
        int frozen;
        int peak;
        int expected_len;
        int cur;

        $readmemh("rtl/sine_quarter.hex", sine_ref);
        resetn     = 1'b0;
        enable     = 1'b0;
        fire       = 1'b0;
        quantity   = 4'd0;
        item_addr  = 4'd0;
        item_we    = 1'b0;
        item_wdata = '0;

        start_test("reset_stop");
        apply_reset();
        repeat (6) wait_cycle();
        check_equal("degree", `ANGLE_REST, degree);
        check_equal("rope_len", `ROPE_MIN, rope_len);
        check_equal("score", 0, score);
        check_equal("end_point", model_point(`ANGLE_REST, `ROPE_MIN), end_point);
        end_test();

        start_test("item_port");
        for (int i = 0; i < 4; i++) begin
            words[i] = rope_pkg::item_t'($random(seed));
            write_item(4'(i + 4), words[i]);
        end
        for (int i = 0; i < 4; i++) begin
            item_addr = 4'(i + 4);
            wait_cycle();
            check_equal("read word", words[i], item_rdata);
        end
        end_test();

        start_test("swing");
        enable = 1'b1;
        wait_degree(`ANGLE_MIN);
        wait_degree(`ANGLE_MIN + 1);
        wait_degree(`ANGLE_MAX);
        wait_degree(`ANGLE_MAX - 1);
        end_test();

        start_test("miss");
        quantity = 4'd0;
        fire = 1'b1;
        wait_cycle();
        fire = 1'b0;
        follow_shot(frozen, peak);
        check_equal("fired degree", `ANGLE_MAX - 1, frozen);
        check_equal("edge at peak", 1, outside_edges(model_point(8'(frozen), 10'(peak))));
        check_equal("inside before peak", 0,
                    outside_edges(model_point(8'(frozen), 10'(peak - `ROPE_DELTA))));
        wait_degree(frozen - 1);
        check_equal("rope_len", `ROPE_MIN, rope_len);
        // nothing has been collected since reset
        check_equal("score", 0, score);
        end_test();

        start_test("grab_score");
        enable = 1'b0;
        apply_reset();
        target = '0;
        target.x = 9'd70;
        target.y = 8'd100;
        target.kind = 2'($random(seed));
        target.visible = 1'b1;
        write_item(4'd0, target);
        item_addr = 4'd0;
        quantity = 4'd1;
        expected_len = `ROPE_MIN + `ROPE_DELTA;
        while (!in_hitbox(target, model_point(`ANGLE_REST, 10'(expected_len)))) begin
            expected_len = expected_len + `ROPE_DELTA;
        end
        enable = 1'b1;
        wait_cycle();
        fire = 1'b1;
        wait_cycle();
        fire = 1'b0;
        follow_shot(frozen, peak);
        check_equal("fired degree", `ANGLE_REST, frozen);
        check_equal("stop length", expected_len, peak);
        last_word = item_rdata;
        while (rope_len != `ROPE_MIN) begin
            cur = rope_len;
            if (cur >= `COLLECT_LEN) begin
                p = model_point(`ANGLE_REST, 10'(cur));
                // wait for the carry write to show on the level port
                while (item_rdata == last_word && rope_len == cur) begin
                    wait_cycle();
                end
                check_equal("carried moving", 1, item_rdata.moving);
                check_equal("carried x", 9'(p.x - `CARRY_OFFSET), item_rdata.x);
                check_equal("carried y", 8'(p.y - `CARRY_OFFSET), item_rdata.y);
                last_word = item_rdata;
            end
            while (rope_len == cur) begin
                wait_cycle();
            end
        end
        check_equal("score", kind_score(target.kind), score);
        check_equal("visible", 0, item_rdata.visible);
        check_equal("moving", 0, item_rdata.moving);
        end_test();

        $display("tests passed %0d, tests failed %0d, check failures %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rope_top.f */
+incdir+rtl
rtl/rope_pkg.sv
rtl/rope_geometry.sv
rtl/frame_timer.sv
rtl/item_ram.sv
rtl/rope_controller.sv
rtl/rope_top.sv
dv/rope_tb.sv

/* Bender.yml */
package:
  name: rope_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rope_pkg.sv
      - rtl/rope_geometry.sv
      - rtl/frame_timer.sv
      - rtl/item_ram.sv
      - rtl/rope_controller.sv
      - rtl/rope_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/rope_tb.sv

/* rtl/sine_quarter.hex */
// sin(deg) * 256, one 9-bit word per degree from 0 to 90
000
004
009
00d
012
016
01b
01f
024
028
02c
031
035
03a
03e
042
047
04b
04f
053
058
05c
060
064
068
06c
070
074
078
07c
080
084
088
08b
08f
093
096
09a
09e
0a1
0a5
0a8
0ab
0af
0b2
0b5
0b8
0bb
0be
0c1
0c4
0c7
0ca
0cc
0cf
0d2
0d4
0d7
0d9
0db
0de
0e0
0e2
0e4
0e6
0e8
0ea
0ec
0ed
0ef
0f1
0f2
0f3
0f5
0f6
0f7
0f8
0f9
0fa
0fb
0fc
0fd
0fe
0fe
0ff
0ff
0ff
100
100
100
100
